// ==== issue_pkg.sv ====
// Shared widths, register map and bus structs for the dual-issue stage
// Imported by every RTL block of the issue stage
package issue_pkg;

    localparam int XLEN      = 32;
    localparam int NUM_REGS  = 32;
    localparam int REG_IDX_W = 5;
    localparam int RD_PORTS  = 4;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Instruction field positions
    localparam int RA_LSB = 15;
    localparam int RB_LSB = 20;
    localparam int RD_LSB = 7;

    localparam int INSTR_BYTES = 4;
    localparam int PAIR_BYTES  = 8;

    // APB register map
    localparam int APB_ADDR_W = 8;
    localparam logic [APB_ADDR_W-1:0] CTRL_ADDR    = 8'h00;
    localparam logic [APB_ADDR_W-1:0] ISSUED_ADDR  = 8'h04;
    localparam logic [APB_ADDR_W-1:0] MISPRED_ADDR = 8'h08;
    localparam int CTRL_DUAL_BIT = 0;

    typedef struct packed {
        logic alu;
        logic lsu;
        logic mul;
        logic branch;
        logic rd_valid;
    } instr_class_t;

    typedef struct packed {
        logic         valid;
        xlen_t        pc;
        xlen_t        instr;
        instr_class_t cls;
    } fetch_word_t;

    typedef struct packed {
        logic     valid;
        xlen_t    pc;
        xlen_t    opcode;
        reg_idx_t rd;
        reg_idx_t ra;
        reg_idx_t rb;
        xlen_t    ra_val;
        xlen_t    rb_val;
    } issue_op_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        xlen_t    value;
    } wb_t;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        xlen_t                 pwdata;
    } apb_req_t;

    typedef struct packed {
        xlen_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

    // Outcome of matching the fetch pair against the expected PC
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_WORD0,
        SEL_WORD1,
        SEL_MISS
    } slot_sel_t;

endpackage

// ==== issue_cfg_regs.sv ====
// APB slave holding the dual-issue enable and the issue and mispredict counters
// Zero wait states; bad offsets and writes to counters answer with pslverr
module issue_cfg_regs
    import issue_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  apb_req_t apb_req_i,
    input  logic     issue_a_i,
    input  logic     issue_b_i,
    input  logic     miss_i,
    output apb_rsp_t apb_rsp_o,
    output logic     dual_en_o
);

    logic  access;
    logic  ctrl_wr;
    logic  addr_known;
    xlen_t rdata;
    logic  dual_q;
    xlen_t issued_q;
    xlen_t mispred_q;

    assign access  = apb_req_i.psel && apb_req_i.penable;
    assign ctrl_wr = access && apb_req_i.pwrite && (apb_req_i.paddr == CTRL_ADDR);

    //--------------------------------------------------
    // Read mux
    //--------------------------------------------------
    always_comb
    begin
        rdata      = '0;
        addr_known = 1'b1;
        case (apb_req_i.paddr)
            CTRL_ADDR:    rdata[CTRL_DUAL_BIT] = dual_q;
            ISSUED_ADDR:  rdata = issued_q;
            MISPRED_ADDR: rdata = mispred_q;
            default:      addr_known = 1'b0;
        endcase
    end

    assign apb_rsp_o.prdata  = rdata;
    assign apb_rsp_o.pready  = 1'b1;
    // Only CTRL is writable
    assign apb_rsp_o.pslverr = access &&
                               (apb_req_i.pwrite ? (apb_req_i.paddr != CTRL_ADDR) : !addr_known);

    //--------------------------------------------------
    // Control and event counters
    //--------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            dual_q <= 1'b1;
        end
        else if (ctrl_wr)
        begin
            dual_q <= apb_req_i.pwdata[CTRL_DUAL_BIT];
        end
    end

    // Both counters wrap
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            issued_q  <= '0;
            mispred_q <= '0;
        end
        else
        begin
            issued_q <= issued_q + xlen_t'(issue_a_i) + xlen_t'(issue_b_i);
            if (miss_i)
                mispred_q <= mispred_q + 1'b1;
        end
    end

    assign dual_en_o = dual_q;

endmodule

// ==== fetch_align.sv ====
// Tracks the expected PC, lines the fetched pair up into issue slots A and B
// and raises a redirect when neither word carries the expected PC
module fetch_align
    import issue_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  fetch_word_t fetch0_i,
    input  fetch_word_t fetch1_i,
    input  logic        redirect_i,
    input  xlen_t       redirect_pc_i,
    input  logic        issue_a_i,
    input  logic        issue_b_i,
    output fetch_word_t slot_a_o,
    output fetch_word_t slot_b_o,
    output logic        miss_o,
    output logic        fetch0_accept_o,
    output logic        fetch1_accept_o,
    output logic        branch_request_o,
    output xlen_t       branch_pc_o
);

    xlen_t     pc_q;
    slot_sel_t sel;
    logic      match0;
    logic      match1;

    // Word-aligned compare, low bits ignored
    assign match0 = fetch0_i.valid && (fetch0_i.pc[XLEN-1:2] == pc_q[XLEN-1:2]);
    assign match1 = fetch1_i.valid && (fetch1_i.pc[XLEN-1:2] == pc_q[XLEN-1:2]);

    always_comb
    begin
        if (redirect_i)
            sel = SEL_NONE;
        else if (match0)
            sel = SEL_WORD0;
        else if (match1)
            sel = SEL_WORD1;
        else if (fetch0_i.valid || fetch1_i.valid)
            sel = SEL_MISS;
        else
            sel = SEL_NONE;
    end

    always_comb
    begin
        slot_a_o = '0;
        slot_b_o = '0;
        case (sel)
            SEL_WORD0:
            begin
                slot_a_o = fetch0_i;
                slot_b_o = fetch1_i;
            end
            SEL_WORD1: slot_a_o = fetch1_i;
            default:   ;
        endcase
    end

    assign miss_o           = (sel == SEL_MISS);
    assign branch_request_o = miss_o;
    assign branch_pc_o      = pc_q;

    // Word 0 is dropped when the pair starts at word 1
    assign fetch0_accept_o = issue_a_i && fetch0_i.valid;
    assign fetch1_accept_o = (issue_a_i && (sel == SEL_WORD1)) || issue_b_i;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            pc_q <= '0;
        else if (redirect_i)
            pc_q <= redirect_pc_i;
        else if (issue_b_i)
            pc_q <= pc_q + xlen_t'(PAIR_BYTES);
        else if (issue_a_i)
            pc_q <= pc_q + xlen_t'(INSTR_BYTES);
    end

endmodule

// ==== issue_sched.sv ====
// Dual-issue scheduler: pairing table, busy-register scoreboard and operand fill
// Issue is combinational from the slot candidates; the scoreboard updates on the edge
module issue_sched
    import issue_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  fetch_word_t slot_a_i,
    input  fetch_word_t slot_b_i,
    input  wb_t         wb0_i,
    input  wb_t         wb1_i,
    input  logic        hold_i,
    input  logic        dual_en_i,
    input  xlen_t       ra_val_i [RD_PORTS],
    output reg_idx_t    rd_idx_o [RD_PORTS],
    output logic        issue_a_o,
    output logic        issue_b_o,
    output issue_op_t   op0_o,
    output issue_op_t   op1_o
);

    reg_idx_t            a_ra, a_rb, a_rd;
    reg_idx_t            b_ra, b_rb, b_rd;
    logic                a_writes;
    logic                b_writes;
    logic                a_blocked;
    logic                b_blocked;
    logic                b_dep;
    logic [NUM_REGS-1:0] busy_q;
    logic [NUM_REGS-1:0] wb_clr;
    logic [NUM_REGS-1:0] busy_now;
    logic [NUM_REGS-1:0] busy_set;

    // Pairs the two execution pipes can run together
    function automatic logic pair_ok(input instr_class_t a, input instr_class_t b);
        logic a_any;
        a_any   = a.alu || a.lsu || a.mul;
        pair_ok = (a_any && (b.alu || b.branch)) ||
                  ((a.alu || a.mul) && b.lsu) ||
                  ((a.alu || a.lsu) && b.mul);
    endfunction

    assign a_ra = slot_a_i.instr[RA_LSB +: REG_IDX_W];
    assign a_rb = slot_a_i.instr[RB_LSB +: REG_IDX_W];
    assign a_rd = slot_a_i.instr[RD_LSB +: REG_IDX_W];
    assign b_ra = slot_b_i.instr[RA_LSB +: REG_IDX_W];
    assign b_rb = slot_b_i.instr[RB_LSB +: REG_IDX_W];
    assign b_rd = slot_b_i.instr[RD_LSB +: REG_IDX_W];

    assign a_writes = slot_a_i.cls.rd_valid && (a_rd != '0);
    assign b_writes = slot_b_i.cls.rd_valid && (b_rd != '0);

    //--------------------------------------------------
    // Scoreboard
    //--------------------------------------------------
    // A writeback this cycle frees its register at once
    always_comb
    begin
        wb_clr = '0;
        if (wb0_i.valid)
            wb_clr[wb0_i.rd] = 1'b1;
        if (wb1_i.valid)
            wb_clr[wb1_i.rd] = 1'b1;
    end

    assign busy_now  = busy_q & ~wb_clr;
    assign a_blocked = busy_now[a_ra] || busy_now[a_rb] || busy_now[a_rd];
    assign b_blocked = busy_now[b_ra] || busy_now[b_rb] || busy_now[b_rd];
    // Slot B may not touch what slot A is about to write
    assign b_dep     = a_writes && ((b_ra == a_rd) || (b_rb == a_rd) || (b_rd == a_rd));

    assign issue_a_o = slot_a_i.valid && !hold_i && !a_blocked;
    assign issue_b_o = issue_a_o && dual_en_i && slot_b_i.valid &&
                       pair_ok(slot_a_i.cls, slot_b_i.cls) && !b_blocked && !b_dep;

    always_comb
    begin
        busy_set = '0;
        if (issue_a_o && a_writes)
            busy_set[a_rd] = 1'b1;
        if (issue_b_o && b_writes)
            busy_set[b_rd] = 1'b1;
    end

    // New writer wins over a same-cycle writeback; x0 is never set
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            busy_q <= '0;
        else
            busy_q <= busy_now | busy_set;
    end

    //--------------------------------------------------
    // Operand read and issue ops
    //--------------------------------------------------
    assign rd_idx_o[0] = a_ra;
    assign rd_idx_o[1] = a_rb;
    assign rd_idx_o[2] = b_ra;
    assign rd_idx_o[3] = b_rb;

    always_comb
    begin
        op0_o        = '0;
        op0_o.valid  = issue_a_o;
        op0_o.pc     = slot_a_i.pc;
        op0_o.opcode = slot_a_i.instr;
        op0_o.rd     = a_rd;
        op0_o.ra     = a_ra;
        op0_o.rb     = a_rb;
        op0_o.ra_val = (a_ra == '0) ? '0 : ra_val_i[0];
        op0_o.rb_val = (a_rb == '0) ? '0 : ra_val_i[1];

        op1_o        = '0;
        op1_o.valid  = issue_b_o;
        op1_o.pc     = slot_b_i.pc;
        op1_o.opcode = slot_b_i.instr;
        op1_o.rd     = b_rd;
        op1_o.ra     = b_ra;
        op1_o.rb     = b_rb;
        op1_o.ra_val = (b_ra == '0) ? '0 : ra_val_i[2];
        op1_o.rb_val = (b_rb == '0) ? '0 : ra_val_i[3];
    end

endmodule

// ==== regfile.sv ====
// Integer register file with two write and four read ports
// Reads are combinational and see this cycle's writebacks, wb1 taking priority
module regfile
    import issue_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  wb_t      wb0_i,
    input  wb_t      wb1_i,
    input  reg_idx_t rd_idx_i [RD_PORTS],
    output xlen_t    rd_val_o [RD_PORTS]
);

    // x0 has no storage
    xlen_t regs_q [1:NUM_REGS-1];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int r = 1; r < NUM_REGS; r++)
                regs_q[r] <= '0;
        end
        else
        begin
            if (wb0_i.valid && (wb0_i.rd != '0))
                regs_q[wb0_i.rd] <= wb0_i.value;
            // Later write wins on a shared target
            if (wb1_i.valid && (wb1_i.rd != '0))
                regs_q[wb1_i.rd] <= wb1_i.value;
        end
    end

    always_comb
    begin
        for (int p = 0; p < RD_PORTS; p++)
        begin
            rd_val_o[p] = (rd_idx_i[p] == '0) ? '0 : regs_q[rd_idx_i[p]];
            if (wb0_i.valid && (wb0_i.rd == rd_idx_i[p]) && (rd_idx_i[p] != '0))
                rd_val_o[p] = wb0_i.value;
            if (wb1_i.valid && (wb1_i.rd == rd_idx_i[p]) && (rd_idx_i[p] != '0))
                rd_val_o[p] = wb1_i.value;
        end
    end

endmodule

// ==== issue_top.sv ====
// Issue stage top level: fetch alignment, scheduler, register file and APB block
// Execution units and the fetcher sit outside and connect through these ports
module issue_top
    import issue_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  fetch_word_t fetch0_i,
    input  fetch_word_t fetch1_i,
    input  wb_t         wb0_i,
    input  wb_t         wb1_i,
    input  logic        hold_i,
    input  logic        redirect_i,
    input  xlen_t       redirect_pc_i,
    input  apb_req_t    apb_req_i,
    output logic        fetch0_accept_o,
    output logic        fetch1_accept_o,
    output issue_op_t   op0_o,
    output issue_op_t   op1_o,
    output logic        branch_request_o,
    output xlen_t       branch_pc_o,
    output apb_rsp_t    apb_rsp_o
);

    fetch_word_t slot_a;
    fetch_word_t slot_b;
    logic        miss;
    logic        issue_a;
    logic        issue_b;
    logic        dual_en;
    reg_idx_t    rd_idx [RD_PORTS];
    xlen_t       rd_val [RD_PORTS];

    fetch_align i_fetch_align (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fetch0_i         (fetch0_i),
        .fetch1_i         (fetch1_i),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .issue_a_i        (issue_a),
        .issue_b_i        (issue_b),
        .slot_a_o         (slot_a),
        .slot_b_o         (slot_b),
        .miss_o           (miss),
        .fetch0_accept_o  (fetch0_accept_o),
        .fetch1_accept_o  (fetch1_accept_o),
        .branch_request_o (branch_request_o),
        .branch_pc_o      (branch_pc_o)
    );

    issue_sched i_issue_sched (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .slot_a_i  (slot_a),
        .slot_b_i  (slot_b),
        .wb0_i     (wb0_i),
        .wb1_i     (wb1_i),
        .hold_i    (hold_i),
        .dual_en_i (dual_en),
        .ra_val_i  (rd_val),
        .rd_idx_o  (rd_idx),
        .issue_a_o (issue_a),
        .issue_b_o (issue_b),
        .op0_o     (op0_o),
        .op1_o     (op1_o)
    );

    regfile i_regfile (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb0_i    (wb0_i),
        .wb1_i    (wb1_i),
        .rd_idx_i (rd_idx),
        .rd_val_o (rd_val)
    );

    issue_cfg_regs i_cfg_regs (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .apb_req_i (apb_req_i),
        .issue_a_i (issue_a),
        .issue_b_i (issue_b),
        .miss_i    (miss),
        .apb_rsp_o (apb_rsp_o),
        .dual_en_o (dual_en)
    );

endmodule

// ==== tb_issue_chk.sv ====
// Concurrent checks on issue ordering, hold and APB timing
// Bound into issue_sched and issue_cfg_regs from this file
module tb_issue_chk
(
    input logic clk_i,
    input logic rst_i,
    input logic a_valid_i,
    input logic b_valid_i,
    input logic hold_i,
    input logic apb_access_i,
    input logic pready_i
);

    timeunit 1ns;
    timeprecision 100ps;

    // Slot 1 only goes out together with slot 0
    a_op1_needs_op0: assert property (@(posedge clk_i) disable iff (rst_i)
        b_valid_i |-> a_valid_i)
        else $error("slot 1 issued without slot 0");

    a_no_issue_in_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        hold_i |-> !a_valid_i && !b_valid_i)
        else $error("instruction issued while hold was high");

    a_pready_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
        apb_access_i |-> pready_i)
        else $error("pready low in the APB access phase");

endmodule

bind issue_sched tb_issue_chk i_sched_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .a_valid_i    (op0_o.valid),
    .b_valid_i    (op1_o.valid),
    .hold_i       (hold_i),
    .apb_access_i (1'b0),
    .pready_i     (1'b1)
);

bind issue_cfg_regs tb_issue_chk i_cfg_chk (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .a_valid_i    (issue_a_i),
    .b_valid_i    (issue_b_i),
    .hold_i       (1'b0),
    .apb_access_i (apb_req_i.psel && apb_req_i.penable),
    .pready_i     (apb_rsp_o.pready)
);

// ==== tb_top.sv ====
// Testbench for the issue stage: fetch and writeback models, APB driver
// and a reference model that predicts each cycle's issue and operands
module tb_top
    import issue_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic iss_a;
        logic iss_b;
        logic acc0;
        logic acc1;
        logic miss;
    } expect_t;

    logic        clk_i = 1'b0;
    logic        rst_i;
    fetch_word_t fetch0, fetch1;
    wb_t         wb0, wb1;
    logic        hold, redirect;
    xlen_t       redirect_pc;
    apb_req_t    apb_req;
    logic        acc0, acc1, breq;
    issue_op_t   op0, op1;
    xlen_t       bpc;
    apb_rsp_t    apb_rsp;

    // Reference state
    xlen_t               mregs [NUM_REGS];
    logic [NUM_REGS-1:0] mbusy;
    xlen_t               exp_pc, fpc;
    logic                dual_model;
    xlen_t               prog_instr [64];
    instr_class_t        prog_cls [64];
    int                  wbq_rd [$];
    int                  wbq_due [$];
    int                  errors, timeouts, checks, cycle;
    int                  issued_tally, miss_tally, passthru_count;
    logic [31:0]         lfsr_q = 32'd68531;

    always #5 clk_i = !clk_i;

    issue_top i_dut (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .fetch0_i         (fetch0),
        .fetch1_i         (fetch1),
        .wb0_i            (wb0),
        .wb1_i            (wb1),
        .hold_i           (hold),
        .redirect_i       (redirect),
        .redirect_pc_i    (redirect_pc),
        .apb_req_i        (apb_req),
        .fetch0_accept_o  (acc0),
        .fetch1_accept_o  (acc1),
        .op0_o            (op0),
        .op1_o            (op1),
        .branch_request_o (breq),
        .branch_pc_o      (bpc),
        .apb_rsp_o        (apb_rsp)
    );

    //--------------------------------------------------
    // Helpers
    //--------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout: %s", what);
    endtask

    function automatic fetch_word_t make_word(input xlen_t pc, input logic valid);
        fetch_word_t w;
        w.valid = valid;
        w.pc    = pc;
        w.instr = prog_instr[pc[7:2]];
        w.cls   = prog_cls[pc[7:2]];
        return w;
    endfunction

    function automatic logic writes_reg(input fetch_word_t w);
        return w.cls.rd_valid && (w.instr[RD_LSB +: REG_IDX_W] != '0);
    endfunction

    // Pairing table of the two execution pipes
    function automatic logic pair_legal(input instr_class_t a, input instr_class_t b);
        if ((a.alu || a.lsu || a.mul) && (b.alu || b.branch))
            return 1'b1;
        if ((a.alu || a.mul) && b.lsu)
            return 1'b1;
        return (a.alu || a.lsu) && b.mul;
    endfunction

    function automatic xlen_t read_operand(input reg_idx_t idx);
        xlen_t v;
        if (idx == '0)
            return '0;
        v = mregs[idx];
        if (wb0.valid && wb0.rd == idx)
            v = wb0.value;
        if (wb1.valid && wb1.rd == idx)
            v = wb1.value;
        return v;
    endfunction

    function automatic void predict_issue(output expect_t e, output fetch_word_t sa,
                                          output fetch_word_t sb);
        logic [NUM_REGS-1:0] busy;
        logic                m0, m1, blk_a, blk_b, dep;
        reg_idx_t            ard;
        e  = '0;
        sa = '0;
        sb = '0;
        m0 = fetch0.valid && (fetch0.pc[31:2] == exp_pc[31:2]);
        m1 = fetch1.valid && (fetch1.pc[31:2] == exp_pc[31:2]);
        if (!redirect && m0)
        begin
            sa = fetch0;
            sb = fetch1;
        end
        else if (!redirect && m1)
            sa = fetch1;
        else if (!redirect)
            e.miss = fetch0.valid || fetch1.valid;
        busy = mbusy;
        if (wb0.valid)
            busy[wb0.rd] = 1'b0;
        if (wb1.valid)
            busy[wb1.rd] = 1'b0;
        ard   = sa.instr[RD_LSB +: REG_IDX_W];
        blk_a = busy[sa.instr[RA_LSB +: 5]] || busy[sa.instr[RB_LSB +: 5]] || busy[ard];
        blk_b = busy[sb.instr[RA_LSB +: 5]] || busy[sb.instr[RB_LSB +: 5]] ||
                busy[sb.instr[RD_LSB +: 5]];
        dep   = writes_reg(sa) && (sb.instr[RA_LSB +: 5] == ard ||
                sb.instr[RB_LSB +: 5] == ard || sb.instr[RD_LSB +: 5] == ard);
        e.iss_a = sa.valid && !hold && !blk_a;
        e.iss_b = e.iss_a && dual_model && sb.valid && pair_legal(sa.cls, sb.cls) &&
                  !blk_b && !dep;
        e.acc0  = e.iss_a && fetch0.valid;
        e.acc1  = (e.iss_a && !m0) || e.iss_b;
    endfunction

    task automatic check_operands(input string name, input issue_op_t op, input fetch_word_t w);
        reg_idx_t ra, rb;
        ra = w.instr[RA_LSB +: REG_IDX_W];
        rb = w.instr[RB_LSB +: REG_IDX_W];
        check_value({name, " pc"}, w.pc, op.pc);
        check_value({name, " opcode"}, w.instr, op.opcode);
        check_value({name, " rd"}, w.instr[RD_LSB +: REG_IDX_W], op.rd);
        check_value({name, " ra"}, ra, op.ra);
        check_value({name, " rb"}, rb, op.rb);
        check_value({name, " ra_val"}, read_operand(ra), op.ra_val);
        check_value({name, " rb_val"}, read_operand(rb), op.rb_val);
        if ((wb0.valid && ra != 0 && (wb0.rd == ra || wb0.rd == rb)) ||
            (wb1.valid && ra != 0 && (wb1.rd == ra || wb1.rd == rb)))
            passthru_count++;
    endtask

    //--------------------------------------------------
    // One cycle: compare, then step models and drive
    //--------------------------------------------------
    task automatic one_cycle(input logic fetch_en, input logic wrong_ok);
        expect_t     e;
        fetch_word_t sa, sb;
        wb_t         nwb [2];
        int          used, i;
        xlen_t       pres, rpc, req_pc;
        logic [3:0]  pick;
        logic        nhold, nredir;
        @(negedge clk_i);
        predict_issue(e, sa, sb);
        req_pc = bpc;
        check_value("op0 valid", e.iss_a, op0.valid);
        check_value("op1 valid", e.iss_b, op1.valid);
        check_value("fetch0 accept", e.acc0, acc0);
        check_value("fetch1 accept", e.acc1, acc1);
        check_value("branch request", e.miss, breq);
        if (e.miss)
            check_value("branch pc", exp_pc, bpc);
        if (e.iss_a)
            check_operands("op0", op0, sa);
        if (e.iss_b)
            check_operands("op1", op1, sb);
        issued_tally += int'(e.iss_a) + int'(e.iss_b);
        miss_tally   += int'(e.miss);

        @(posedge clk_i);
        cycle++;
        if (wb0.valid)
        begin
            mbusy[wb0.rd] = 1'b0;
            if (wb0.rd != 0)
                mregs[wb0.rd] = wb0.value;
        end
        if (wb1.valid)
        begin
            mbusy[wb1.rd] = 1'b0;
            if (wb1.rd != 0)
                mregs[wb1.rd] = wb1.value;
        end
        // Writers become busy and get a result 1 to 4 cycles later
        if (e.iss_a && writes_reg(sa))
        begin
            mbusy[sa.instr[RD_LSB +: 5]] = 1'b1;
            wbq_rd.push_back(int'(sa.instr[RD_LSB +: 5]));
            wbq_due.push_back(cycle + int'(take_bits(2)));
        end
        if (e.iss_b && writes_reg(sb))
        begin
            mbusy[sb.instr[RD_LSB +: 5]] = 1'b1;
            wbq_rd.push_back(int'(sb.instr[RD_LSB +: 5]));
            wbq_due.push_back(cycle + int'(take_bits(2)));
        end
        if (redirect)
        begin
            exp_pc = redirect_pc;
            fpc    = redirect_pc;
        end
        else
        begin
            if (e.iss_b)
                exp_pc = exp_pc + PAIR_BYTES;
            else if (e.iss_a)
                exp_pc = exp_pc + INSTR_BYTES;
            if (e.miss)
                fpc = req_pc;
            else if (e.acc1)
                fpc = fetch1.pc + INSTR_BYTES;
            else if (e.acc0)
                fpc = fetch0.pc + INSTR_BYTES;
        end

        nwb[0] = '0;
        nwb[1] = '0;
        used   = 0;
        i      = 0;
        while (i < wbq_rd.size())
        begin
            if (used < 2 && wbq_due[i] <= cycle)
            begin
                nwb[used].valid = 1'b1;
                nwb[used].rd    = reg_idx_t'(wbq_rd[i]);
                nwb[used].value = take_bits(32);
                used++;
                wbq_rd.delete(i);
                wbq_due.delete(i);
            end
            else
                i++;
        end

        nhold  = fetch_en && (take_bits(3) == 0);
        nredir = fetch_en && (take_bits(5) == 0);
        rpc    = {24'd0, 6'(take_bits(6)), 2'b00};
        pres   = fpc;
        pick   = 4'(take_bits(4));
        if (fetch_en && wrong_ok && pick == 0)
            pres = fpc + 16;
        else if (fetch_en && pick == 1 && fpc >= 4)
            pres = fpc - 4;

        fetch0      <= make_word(pres, fetch_en);
        fetch1      <= make_word(pres + INSTR_BYTES, fetch_en);
        hold        <= nhold;
        redirect    <= nredir;
        redirect_pc <= rpc;
        wb0         <= nwb[0];
        wb1         <= nwb[1];
    endtask

    task automatic drain_writebacks();
        int n;
        n = 0;
        while (wbq_rd.size() > 0 && n < 40)
        begin
            one_cycle(1'b0, 1'b0);
            n++;
        end
        if (wbq_rd.size() > 0)
            report_timeout("writebacks never drained");
        repeat (2) one_cycle(1'b0, 1'b0);
    endtask

    //--------------------------------------------------
    // APB driver
    //--------------------------------------------------
    task automatic apb_access(input logic write, input logic [7:0] addr, input xlen_t wdata,
                              output xlen_t rdata, output logic err);
        int n;
        @(posedge clk_i);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clk_i);
        apb_req.penable <= 1'b1;
        n = 0;
        do
        begin
            @(negedge clk_i);
            n++;
        end
        while (!apb_rsp.pready && n < 8);
        if (!apb_rsp.pready)
            report_timeout("APB slave never raised pready");
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk_i);
        apb_req <= '0;
    endtask

    task automatic apb_expect(input string name, input logic write, input logic [7:0] addr,
                              input xlen_t wdata, input xlen_t exp_data, input logic exp_err);
        xlen_t d;
        logic  err;
        apb_access(write, addr, wdata, d, err);
        if (!write)
            check_value({name, " data"}, exp_data, d);
        check_value({name, " pslverr"}, exp_err, err);
    endtask

    //--------------------------------------------------
    // Test sequence
    //--------------------------------------------------
    initial
    begin
        rst_i       = 1'b1;
        fetch0      = '0;
        fetch1      = '0;
        wb0         = '0;
        wb1         = '0;
        hold        = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        apb_req     = '0;
        mbusy       = '0;
        exp_pc      = '0;
        fpc         = '0;
        dual_model  = 1'b1;
        for (int r = 0; r < NUM_REGS; r++)
            mregs[r] = '0;
        // Registers limited to x0..x7 so hazards are frequent
        for (int k = 0; k < 64; k++)
        begin
            prog_instr[k] = take_bits(32);
            prog_instr[k][RA_LSB +: 5] = {2'b00, 3'(take_bits(3))};
            prog_instr[k][RB_LSB +: 5] = {2'b00, 3'(take_bits(3))};
            prog_instr[k][RD_LSB +: 5] = {2'b00, 3'(take_bits(3))};
            prog_cls[k] = '0;
            case (take_bits(2))
                0: prog_cls[k].alu = 1'b1;
                1: prog_cls[k].lsu = 1'b1;
                2: prog_cls[k].mul = 1'b1;
                default: prog_cls[k].branch = 1'b1;
            endcase
            prog_cls[k].rd_valid = !prog_cls[k].branch;
        end
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        @(negedge clk_i);
        check_value("reset op0 valid", 0, op0.valid);
        check_value("reset op1 valid", 0, op1.valid);
        check_value("reset accepts", 0, {acc0, acc1});
        check_value("reset branch request", 0, breq);
        apb_expect("reset CTRL", 1'b0, CTRL_ADDR, '0, 32'd1, 1'b0);
        apb_expect("reset ISSUED", 1'b0, ISSUED_ADDR, '0, 32'd0, 1'b0);
        apb_expect("reset MISPRED", 1'b0, MISPRED_ADDR, '0, 32'd0, 1'b0);

        repeat (400) one_cycle(1'b1, 1'b0);
        drain_writebacks();
        apb_expect("ISSUED dual", 1'b0, ISSUED_ADDR, '0, issued_tally, 1'b0);
        check_value("pass-through seen", 1, passthru_count > 0);

        apb_expect("CTRL off", 1'b1, CTRL_ADDR, '0, '0, 1'b0);
        dual_model = 1'b0;
        repeat (200) one_cycle(1'b1, 1'b0);
        drain_writebacks();
        apb_expect("ISSUED single", 1'b0, ISSUED_ADDR, '0, issued_tally, 1'b0);

        apb_expect("CTRL on", 1'b1, CTRL_ADDR, 32'd1, '0, 1'b0);
        dual_model = 1'b1;
        repeat (200) one_cycle(1'b1, 1'b1);
        drain_writebacks();
        check_value("misses seen", 1, miss_tally > 0);
        apb_expect("MISPRED", 1'b0, MISPRED_ADDR, '0, miss_tally, 1'b0);

        apb_expect("read 0xC", 1'b0, 8'h0C, '0, '0, 1'b1);
        apb_expect("write 0xC", 1'b1, 8'h0C, 32'hFFFF_FFFF, '0, 1'b1);
        apb_expect("write ISSUED", 1'b1, ISSUED_ADDR, 32'h0000_DEAD, '0, 1'b1);
        apb_expect("ISSUED kept", 1'b0, ISSUED_ADDR, '0, issued_tally, 1'b0);
        apb_expect("CTRL kept", 1'b0, CTRL_ADDR, '0, 32'd1, 1'b0);

        $display("errors: %0d timeouts: %0d checks: %0d", errors, timeouts, checks);
        if (errors == 0 && timeouts == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== tb.f ====
issue_pkg.sv
issue_cfg_regs.sv
fetch_align.sv
issue_sched.sv
regfile.sv
issue_top.sv
tb_issue_chk.sv
tb_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator and run; passes only when the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_top -f tb.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "sim passed" &&
exit 0 || exit 1
